//--- dv/core_assert.sv
////////////////////////////////////////////////////////////
// core assertions
// write spacing, queue overflow, reset length, read latency
// and read mux checks, bound into core_top
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module core_assert #(
  parameter int RESET_DELAY = 1048576,
  parameter int CART_GAP    = 32,
  parameter int SAVE_GAP    = 16
) (
  input wire                         clk_74a,
  input wire                         pll_core_locked,
  input wire core_pkg::bridge_addr_t bridge_addr,
  input wire                         bridge_wr,
  input wire core_pkg::bridge_data_t bridge_rd_data,
  input wire                         core_reset,
  input wire                         cart_wr,
  input wire                         save_we,
  input wire                         cart_push,
  input wire                         save_push,
  input wire                         cart_full,
  input wire                         save_full,
  input wire                         save_rd,
  input wire core_pkg::bridge_data_t save_rd_data
);

  int         errors = 0;
  logic [7:0] cart_since;
  logic [7:0] save_since;
  int         reset_run;

  // cycles since the last write pulse, saturating
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      cart_since <= '1;
      save_since <= '1;
      reset_run  <= 0;
    end else begin
      if (cart_wr) cart_since <= 8'd1;
      else if (cart_since != '1) cart_since <= cart_since + 8'd1;
      if (save_we) save_since <= 8'd1;
      else if (save_since != '1) save_since <= save_since + 8'd1;
      reset_run <= core_reset ? reset_run + 1 : 0;
    end
  end

  a_cart_gap: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    cart_wr |-> cart_since >= 8'(CART_GAP))
    else begin
      errors++;
      $error("cart writes closer than %0d cycles", CART_GAP);
    end

  a_save_gap: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    save_we |-> save_since >= 8'(SAVE_GAP))
    else begin
      errors++;
      $error("save writes closer than %0d cycles", SAVE_GAP);
    end

  a_cart_overflow: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    cart_push |-> !cart_full)
    else begin
      errors++;
      $error("cart word pushed into a full queue");
    end

  a_save_overflow: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    save_push |-> !save_full)
    else begin
      errors++;
      $error("save word pushed into a full queue");
    end

  a_reset_start: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    bridge_wr && bridge_addr == core_pkg::reg_reset |=> core_reset)
    else begin
      errors++;
      $error("core_reset did not rise after a reset write");
    end

  // first locked cycle is excluded by the past term
  a_reset_len: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    $fell(core_reset) && $past(pll_core_locked) |-> reset_run == RESET_DELAY)
    else begin
      errors++;
      $error("core_reset held %0d cycles", reset_run);
    end

  // read data only moves READ_LATENCY cycles after a save read
  a_rd_latency: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    !$stable(save_rd_data) |-> $past(save_rd, core_pkg::READ_LATENCY))
    else begin
      errors++;
      $error("save read data changed outside the read latency");
    end

  a_rd_zero: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    bridge_addr[31:28] != core_pkg::region_save |-> bridge_rd_data == '0)
    else begin
      errors++;
      $error("nonzero read data outside the save region");
    end

endmodule

bind core_top core_assert #(
  .RESET_DELAY(RESET_DELAY)
) i_core_assert (
  .clk_74a        (clk_74a),
  .pll_core_locked(pll_core_locked),
  .bridge_addr    (bridge_addr),
  .bridge_wr      (bridge_wr),
  .bridge_rd_data (bridge_rd_data),
  .core_reset     (core_reset),
  .cart_wr        (cart_wr),
  .save_we        (save_we),
  .cart_push      (cart_push),
  .save_push      (save_push),
  .cart_full      (i_cart_loader.full),
  .save_full      (i_save_loader.full),
  .save_rd        (save_rd),
  .save_rd_data   (save_rd_data)
);

`default_nettype wire

//--- dv/core_tb.sv
////////////////////////////////////////////////////////////
// core testbench
// bridge stimulus for core_top with models of the settings,
// cart writes and save data
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module core_tb;

  localparam int RESET_DELAY  = 64;
  // the test phases take about 1400 cycles
  localparam int CYCLE_LIMIT  = 20000;
  localparam int NUM_SETTINGS = 10;

  logic                   clk_74a;
  logic                   pll_core_locked;
  core_pkg::bridge_addr_t bridge_addr;
  logic                   bridge_rd;
  logic                   bridge_wr;
  core_pkg::bridge_data_t bridge_wr_data;
  wire [31:0]             bridge_rd_data;
  wire                    core_reset;
  wire                    sgx;
  wire                    cart_download;
  wire                    save_download;
  wire                    turbo_tap_enable;
  wire                    button6_enable;
  wire [1:0]              button1_turbo_speed;
  wire [1:0]              button2_turbo_speed;
  wire [1:0]              master_audio_boost;
  wire                    adpcm_audio_boost;
  wire                    cd_audio_boost;
  wire                    cart_wr;
  wire [23:0]             cart_wr_addr;
  wire [15:0]             cart_wr_data;

  logic [31:0] lfsr;
  int          cycle = 0;
  int          upper_cycle = 0;
  logic [31:0] setting_addr [NUM_SETTINGS];
  string       setting_name [NUM_SETTINGS];
  logic [1:0]  setting_exp [NUM_SETTINGS];
  // lower flag, halfword address, halfword data
  logic [40:0] cart_exp [$];
  logic [40:0] cart_next;
  logic [31:0] save_model [512];

  core_top #(
    .RESET_DELAY(RESET_DELAY)
  ) i_dut (
    .clk_74a            (clk_74a),
    .pll_core_locked    (pll_core_locked),
    .bridge_addr        (bridge_addr),
    .bridge_rd          (bridge_rd),
    .bridge_wr          (bridge_wr),
    .bridge_wr_data     (bridge_wr_data),
    .bridge_rd_data     (bridge_rd_data),
    .core_reset         (core_reset),
    .sgx                (sgx),
    .cart_download      (cart_download),
    .save_download      (save_download),
    .turbo_tap_enable   (turbo_tap_enable),
    .button6_enable     (button6_enable),
    .button1_turbo_speed(button1_turbo_speed),
    .button2_turbo_speed(button2_turbo_speed),
    .master_audio_boost (master_audio_boost),
    .adpcm_audio_boost  (adpcm_audio_boost),
    .cd_audio_boost     (cd_audio_boost),
    .cart_wr            (cart_wr),
    .cart_wr_addr       (cart_wr_addr),
    .cart_wr_data       (cart_wr_data)
  );

  initial begin
    clk_74a = 1'b0;
    forever #5 clk_74a = ~clk_74a;
  end

  ////////////////////////////////////////////////////////////
  // helpers

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("SOME TESTS FAILED");
    $fatal(1, "run stopped at the first failure");
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      fail_now($sformatf("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // fibonacci lfsr, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] value);
    value = '0;
    for (int i = 0; i < n; i++) begin
      lfsr  = lfsr_next(lfsr);
      value = {value[30:0], lfsr[0]};
    end
  endtask

  function automatic logic [1:0] setting_out(input int i);
    case (i)
      0:       return {1'b0, cart_download};
      1:       return {1'b0, save_download};
      2:       return {1'b0, sgx};
      3:       return {1'b0, turbo_tap_enable};
      4:       return {1'b0, button6_enable};
      5:       return button1_turbo_speed;
      6:       return button2_turbo_speed;
      7:       return master_audio_boost;
      8:       return {1'b0, adpcm_audio_boost};
      default: return {1'b0, cd_audio_boost};
    endcase
  endfunction

  task automatic check_settings();
    for (int i = 0; i < NUM_SETTINGS; i++) begin
      check_value(setting_name[i], {30'h0, setting_out(i)}, {30'h0, setting_exp[i]});
    end
  endtask

  // called on a falling edge, returns one cycle later
  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(negedge clk_74a);
    bridge_wr = 1'b0;
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data);
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    @(negedge clk_74a);
    bridge_rd = 1'b0;
    repeat (core_pkg::READ_LATENCY - 1) @(negedge clk_74a);
    data = bridge_rd_data;
  endtask

  task automatic cart_word();
    logic [31:0] addr;
    logic [31:0] data;
    draw_bits(22, addr);
    draw_bits(32, data);
    addr = {8'h10, addr[21:0], 2'b00};
    cart_exp.push_back({1'b0, addr[23:0], data[31:16]});
    cart_exp.push_back({1'b1, addr[23:0] + 24'd2, data[15:0]});
    bus_write(addr, data);
  endtask

  ////////////////////////////////////////////////////////////
  // watchdog and cart write monitor

  always @(posedge clk_74a) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) fail_now("timeout, the tests did not finish in time");
  end

  always @(negedge clk_74a) begin
    if (i_dut.i_core_assert.errors != 0) fail_now("an assertion in core_assert failed");
    if (pll_core_locked && cart_wr) begin
      if (cart_exp.size() == 0) begin
        fail_now("cart_wr pulsed with no cart word pending");
      end else begin
        cart_next = cart_exp.pop_front();
        check_value("cart_wr_addr", {8'h00, cart_wr_addr}, {8'h00, cart_next[39:16]});
        check_value("cart_wr_data", {16'h0, cart_wr_data}, {16'h0, cart_next[15:0]});
        if (cart_next[40]) check_value("cart_wr gap", 32'(cycle - upper_cycle), 32'd32);
        else upper_cycle = cycle;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // test sequence

  initial begin
    logic [31:0] value;
    logic [31:0] addr;
    logic [31:0] got;
    int          n;
    logic [8:0]  save_idx [$];
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_rd       = 1'b0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    lfsr            = 32'hb1ac;
    setting_addr = '{core_pkg::reg_cart_download, core_pkg::reg_save_download,
                     core_pkg::reg_sgx, core_pkg::reg_turbo_tap, core_pkg::reg_button6,
                     core_pkg::reg_button1_speed, core_pkg::reg_button2_speed,
                     core_pkg::reg_master_boost, core_pkg::reg_adpcm_boost,
                     core_pkg::reg_cd_boost};
    setting_name = '{"cart_download", "save_download", "sgx", "turbo_tap_enable",
                     "button6_enable", "button1_turbo_speed", "button2_turbo_speed",
                     "master_audio_boost", "adpcm_audio_boost", "cd_audio_boost"};
    setting_exp  = '{default: 2'b00};
    repeat (16) @(negedge clk_74a);
    pll_core_locked = 1'b1;
    @(negedge clk_74a);

    // state after reset
    check_settings();
    check_value("core_reset", {31'h0, core_reset}, 32'h0);
    check_value("cart_wr", {31'h0, cart_wr}, 32'h0);
    check_value("bridge_rd_data", bridge_rd_data, 32'h0);

    // two passes over the register map, then an unmapped address
    for (int k = 0; k < 2 * NUM_SETTINGS; k++) begin
      draw_bits(32, value);
      bus_write(setting_addr[k % NUM_SETTINGS], value);
      if (k % NUM_SETTINGS >= 5 && k % NUM_SETTINGS <= 7) begin
        setting_exp[k % NUM_SETTINGS] = value[1:0];
      end else begin
        setting_exp[k % NUM_SETTINGS] = {1'b0, value[0]};
      end
      check_settings();
    end
    draw_bits(32, value);
    bus_write(32'h0000_0200, value);
    check_settings();

    // delayed core reset
    bus_write(core_pkg::reg_reset, 32'h1);
    n = 0;
    while (core_reset && n <= RESET_DELAY) begin
      n++;
      @(negedge clk_74a);
    end
    check_value("core_reset high cycles", 32'(n), 32'(RESET_DELAY));

    // paced cart words, then a burst of four
    for (int k = 0; k < 6; k++) begin
      cart_word();
      repeat (64) @(negedge clk_74a);
    end
    for (int k = 0; k < 4; k++) cart_word();
    while (cart_exp.size() != 0) @(negedge clk_74a);

    // save writes and readback
    for (int k = 0; k < 8; k++) begin
      draw_bits(9, addr);
      draw_bits(32, value);
      save_model[addr[8:0]] = value;
      save_idx.push_back(addr[8:0]);
      bus_write({4'h2, 17'h0, addr[8:0], 2'b00}, value);
      repeat (64) @(negedge clk_74a);
    end
    foreach (save_idx[k]) begin
      bus_read({4'h2, 17'h0, save_idx[k], 2'b00}, got);
      check_value("bridge_rd_data", got, save_model[save_idx[k]]);
    end

    // reads outside the save region
    for (int k = 0; k < 3; k++) begin
      draw_bits(28, value);
      bus_read({4'(k * 5 + 1), value[27:0]}, got);
      check_value("bridge_rd_data", got, 32'h0);
    end

    repeat (8) @(negedge clk_74a);
    if (i_dut.i_core_assert.errors != 0) begin
      fail_now("an assertion in core_assert failed");
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# build and run the core testbench with verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module core_tb -f src.f -o core_sim \
  && ./obj_dir/core_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2> /dev/null
grep -q "ALL TESTS PASSED" sim.log 2> /dev/null && echo "PASS" && exit 0 \
  || { echo "FAIL"; exit 1; }

//--- src.f
verilog/core_pkg.sv
verilog/save_buffer.sv
verilog/save_unloader.sv
verilog/data_loader.sv
verilog/bridge_ctrl.sv
verilog/core_top.sv
dv/core_assert.sv
dv/core_tb.sv

//--- verilog/bridge_ctrl.sv
////////////////////////////////////////////////////////////
// bridge control
// region decode of bridge strobes, settings registers,
// delayed core reset and the bridge read mux
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module bridge_ctrl #(
  parameter int RESET_DELAY = 1048576
) (
  input  wire                         clk_74a,
  input  wire                         pll_core_locked,
  input  wire core_pkg::bridge_addr_t bridge_addr,
  input  wire                         bridge_rd,
  input  wire                         bridge_wr,
  input  wire core_pkg::bridge_data_t bridge_wr_data,
  input  wire core_pkg::bridge_data_t save_rd_data,
  output core_pkg::bridge_data_t      bridge_rd_data,
  output logic                        cart_push,
  output logic                        save_push,
  output logic                        save_rd,
  output core_pkg::bridge_addr_t      push_addr,
  output core_pkg::bridge_data_t      push_data,
  output logic                        core_reset,
  output logic                        sgx,
  output logic                        cart_download,
  output logic                        save_download,
  output logic                        turbo_tap_enable,
  output logic                        button6_enable,
  output core_pkg::speed_t            button1_turbo_speed,
  output core_pkg::speed_t            button2_turbo_speed,
  output core_pkg::speed_t            master_audio_boost,
  output logic                        adpcm_audio_boost,
  output logic                        cd_audio_boost
);

  localparam int COUNT_WIDTH = $clog2(RESET_DELAY + 1);

  core_pkg::region_e      region;
  core_pkg::bridge_reg_e  wr_reg;
  logic                   reg_wr;
  logic [COUNT_WIDTH-1:0] reset_count;

  // top nibble selects the device
  always_comb begin
    case (bridge_addr[31:28])
      4'h1:    region = core_pkg::region_cart;
      4'h2:    region = core_pkg::region_save;
      default: region = core_pkg::region_other;
    endcase
  end

  // loaders see address and data in the strobe cycle
  assign cart_push = bridge_wr && region == core_pkg::region_cart;
  assign save_push = bridge_wr && region == core_pkg::region_save;
  assign save_rd   = bridge_rd && region == core_pkg::region_save;
  assign push_addr = bridge_addr;
  assign push_data = bridge_wr_data;

  // only save reads return data, the rest read as zero
  assign bridge_rd_data = (region == core_pkg::region_save) ? save_rd_data : '0;

  ////////////////////////////////////////////////////////////
  // settings and reset delay

  assign reg_wr = bridge_wr && region == core_pkg::region_other;
  assign wr_reg = core_pkg::bridge_reg_e'(bridge_addr);

  // held in reset while the pll is unlocked or the delay runs
  assign core_reset = !pll_core_locked || reset_count != '0;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      reset_count         <= '0;
      sgx                 <= 1'b0;
      cart_download       <= 1'b0;
      save_download       <= 1'b0;
      turbo_tap_enable    <= 1'b0;
      button6_enable      <= 1'b0;
      button1_turbo_speed <= '0;
      button2_turbo_speed <= '0;
      master_audio_boost  <= '0;
      adpcm_audio_boost   <= 1'b0;
      cd_audio_boost      <= 1'b0;
    end else begin
      if (reset_count != '0) begin
        reset_count <= reset_count - COUNT_WIDTH'(1);
      end
      if (reg_wr) begin
        case (wr_reg)
          core_pkg::reg_cart_download: cart_download       <= bridge_wr_data[0];
          core_pkg::reg_save_download: save_download       <= bridge_wr_data[0];
          core_pkg::reg_sgx:           sgx                 <= bridge_wr_data[0];
          // a second write restarts the delay
          core_pkg::reg_reset:         reset_count         <= COUNT_WIDTH'(RESET_DELAY);
          core_pkg::reg_turbo_tap:     turbo_tap_enable    <= bridge_wr_data[0];
          core_pkg::reg_button6:       button6_enable      <= bridge_wr_data[0];
          core_pkg::reg_button1_speed: button1_turbo_speed <= bridge_wr_data[1:0];
          core_pkg::reg_button2_speed: button2_turbo_speed <= bridge_wr_data[1:0];
          core_pkg::reg_master_boost:  master_audio_boost  <= bridge_wr_data[1:0];
          core_pkg::reg_adpcm_boost:   adpcm_audio_boost   <= bridge_wr_data[0];
          core_pkg::reg_cd_boost:      cd_audio_boost      <= bridge_wr_data[0];
          default: ;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/core_pkg.sv
////////////////////////////////////////////////////////////
// core package
// bridge bus types, address regions, settings register map
// and the fixed save read latency
////////////////////////////////////////////////////////////

`default_nettype none

package core_pkg;

  typedef logic [31:0] bridge_addr_t;
  typedef logic [31:0] bridge_data_t;
  typedef logic [15:0] half_t;

  // turbo speed or master boost level
  typedef logic [1:0] speed_t;

  // top nibble of the bridge address
  typedef enum logic [3:0] {
    region_cart  = 4'h1,
    region_save  = 4'h2,
    region_other = 4'h0
  } region_e;

  // settings registers, by word address in the low region
  typedef enum logic [31:0] {
    reg_cart_download = 32'h0000_0000,
    reg_save_download = 32'h0000_0004,
    reg_sgx           = 32'h0000_0008,
    reg_reset         = 32'h0000_0050,
    reg_turbo_tap     = 32'h0000_0100,
    reg_button6       = 32'h0000_0104,
    reg_button1_speed = 32'h0000_0108,
    reg_button2_speed = 32'h0000_010C,
    reg_master_boost  = 32'h0000_0300,
    reg_adpcm_boost   = 32'h0000_0304,
    reg_cd_boost      = 32'h0000_0308
  } bridge_reg_e;

  // save read strobe to valid bridge read data, in cycles
  localparam int READ_LATENCY = 4;

endpackage

`default_nettype wire

//--- verilog/core_top.sv
////////////////////////////////////////////////////////////
// core top
// bridge control, cart and save loaders, save unloader
// and the on-chip save buffer, all on clk_74a
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module core_top #(
  parameter int RESET_DELAY     = 1048576,
  parameter int SAVE_ADDR_WIDTH = 10
) (
  input  wire                         clk_74a,
  input  wire                         pll_core_locked,
  input  wire core_pkg::bridge_addr_t bridge_addr,
  input  wire                         bridge_rd,
  input  wire                         bridge_wr,
  input  wire core_pkg::bridge_data_t bridge_wr_data,
  output wire core_pkg::bridge_data_t bridge_rd_data,
  output wire                         core_reset,
  output wire                         sgx,
  output wire                         cart_download,
  output wire                         save_download,
  output wire                         turbo_tap_enable,
  output wire                         button6_enable,
  output wire core_pkg::speed_t       button1_turbo_speed,
  output wire core_pkg::speed_t       button2_turbo_speed,
  output wire core_pkg::speed_t       master_audio_boost,
  output wire                         adpcm_audio_boost,
  output wire                         cd_audio_boost,
  output wire                         cart_wr,
  output wire [23:0]                  cart_wr_addr,
  output wire core_pkg::half_t        cart_wr_data
);

  wire                         cart_push;
  wire                         save_push;
  wire                         save_rd;
  wire core_pkg::bridge_addr_t push_addr;
  wire core_pkg::bridge_data_t push_data;
  wire core_pkg::bridge_data_t save_rd_data;

  // save buffer ports, byte addressed
  wire                         save_we;
  wire [SAVE_ADDR_WIDTH:0]     save_waddr;
  wire core_pkg::half_t        save_wdata;
  wire [SAVE_ADDR_WIDTH:0]     save_raddr;
  wire core_pkg::half_t        save_q;

  bridge_ctrl #(
    .RESET_DELAY(RESET_DELAY)
  ) i_bridge_ctrl (
    .clk_74a            (clk_74a),
    .pll_core_locked    (pll_core_locked),
    .bridge_addr        (bridge_addr),
    .bridge_rd          (bridge_rd),
    .bridge_wr          (bridge_wr),
    .bridge_wr_data     (bridge_wr_data),
    .save_rd_data       (save_rd_data),
    .bridge_rd_data     (bridge_rd_data),
    .cart_push          (cart_push),
    .save_push          (save_push),
    .save_rd            (save_rd),
    .push_addr          (push_addr),
    .push_data          (push_data),
    .core_reset         (core_reset),
    .sgx                (sgx),
    .cart_download      (cart_download),
    .save_download      (save_download),
    .turbo_tap_enable   (turbo_tap_enable),
    .button6_enable     (button6_enable),
    .button1_turbo_speed(button1_turbo_speed),
    .button2_turbo_speed(button2_turbo_speed),
    .master_audio_boost (master_audio_boost),
    .adpcm_audio_boost  (adpcm_audio_boost),
    .cd_audio_boost     (cd_audio_boost)
  );

  ////////////////////////////////////////////////////////////
  // cart and save loaders

  data_loader #(
    .ADDR_WIDTH(24),
    .WRITE_GAP (32)
  ) i_cart_loader (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .push           (cart_push),
    .push_addr      (push_addr),
    .push_data      (push_data),
    .write_en       (cart_wr),
    .write_addr     (cart_wr_addr),
    .write_data     (cart_wr_data)
  );

  data_loader #(
    .ADDR_WIDTH(SAVE_ADDR_WIDTH + 1),
    .WRITE_GAP (16)
  ) i_save_loader (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .push           (save_push),
    .push_addr      (push_addr),
    .push_data      (push_data),
    .write_en       (save_we),
    .write_addr     (save_waddr),
    .write_data     (save_wdata)
  );

  ////////////////////////////////////////////////////////////
  // save readback path

  save_unloader #(
    .SAVE_ADDR_WIDTH(SAVE_ADDR_WIDTH)
  ) i_save_unloader (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .save_rd        (save_rd),
    .rd_addr        (bridge_addr),
    .buf_q          (save_q),
    .buf_raddr      (save_raddr),
    .save_rd_data   (save_rd_data)
  );

  save_buffer #(
    .SAVE_ADDR_WIDTH(SAVE_ADDR_WIDTH)
  ) i_save_buffer (
    .clk_74a(clk_74a),
    .we     (save_we),
    .waddr  (save_waddr),
    .wdata  (save_wdata),
    .raddr  (save_raddr),
    .q      (save_q)
  );

endmodule

`default_nettype wire

//--- verilog/data_loader.sv
////////////////////////////////////////////////////////////
// data loader
// four-word queue of bridge writes, each word split into
// two halfword writes spaced WRITE_GAP cycles apart
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module data_loader #(
  parameter int ADDR_WIDTH = 24,
  parameter int WRITE_GAP  = 32
) (
  input  wire                         clk_74a,
  input  wire                         pll_core_locked,
  input  wire                         push,
  input  wire core_pkg::bridge_addr_t push_addr,
  input  wire core_pkg::bridge_data_t push_data,
  output logic                        write_en,
  output logic [ADDR_WIDTH-1:0]       write_addr,
  output core_pkg::half_t             write_data
);

  localparam int TIMER_WIDTH = $clog2(WRITE_GAP);

  typedef enum logic [1:0] {
    st_idle,
    st_upper,
    st_gap,
    st_lower
  } state_e;

  state_e                 state;
  logic [TIMER_WIDTH-1:0] timer;
  logic                   lower_done;
  logic [ADDR_WIDTH-1:0]  cur_addr;
  core_pkg::bridge_data_t cur_data;
  logic [ADDR_WIDTH-1:0]  q_addr [4];
  core_pkg::bridge_data_t q_data [4];
  logic [1:0]             wr_ptr;
  logic [1:0]             rd_ptr;
  logic [2:0]             q_count;
  logic                   full;
  logic                   accept;
  logic                   gap_done;
  logic                   pop;

  assign full     = q_count == 3'd4;
  assign accept   = push && !full;
  assign gap_done = state == st_gap && timer == '0;
  // next word starts from idle or right after the trailing gap
  assign pop = q_count != 3'd0 && (state == st_idle || (gap_done && lower_done));

  always_ff @(posedge clk_74a) begin
    if (accept) begin
      q_addr[wr_ptr] <= push_addr[ADDR_WIDTH-1:0];
      q_data[wr_ptr] <= push_data;
    end
    if (pop) begin
      cur_addr <= q_addr[rd_ptr];
      cur_data <= q_data[rd_ptr];
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      q_count    <= '0;
      state      <= st_idle;
      timer      <= '0;
      lower_done <= 1'b0;
    end else begin
      if (accept) wr_ptr <= wr_ptr + 2'd1;
      if (pop) rd_ptr <= rd_ptr + 2'd1;
      if (accept && !pop) q_count <= q_count + 3'd1;
      else if (pop && !accept) q_count <= q_count - 3'd1;
      if (timer != '0) timer <= timer - TIMER_WIDTH'(1);
      // the pulse cycle plus WRITE_GAP-1 gap cycles between pulses
      case (state)
        st_idle: if (pop) state <= st_upper;
        st_upper: begin
          state      <= st_gap;
          timer      <= TIMER_WIDTH'(WRITE_GAP - 2);
          lower_done <= 1'b0;
        end
        st_gap: begin
          if (gap_done) begin
            if (!lower_done) state <= st_lower;
            else if (pop) state <= st_upper;
            else state <= st_idle;
          end
        end
        st_lower: begin
          state      <= st_gap;
          timer      <= TIMER_WIDTH'(WRITE_GAP - 2);
          lower_done <= 1'b1;
        end
      endcase
    end
  end

  // big-endian, upper halfword first
  assign write_en   = state == st_upper || state == st_lower;
  assign write_addr = (state == st_lower) ? cur_addr + ADDR_WIDTH'(2) : cur_addr;
  assign write_data = (state == st_lower) ? cur_data[15:0] : cur_data[31:16];

endmodule

`default_nettype wire

//--- verilog/save_buffer.sv
////////////////////////////////////////////////////////////
// save buffer
// dual-port halfword ram with registered read
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module save_buffer #(
  parameter int SAVE_ADDR_WIDTH = 10
) (
  input  wire                         clk_74a,
  input  wire                         we,
  input  wire [SAVE_ADDR_WIDTH:0]     waddr,
  input  wire core_pkg::half_t        wdata,
  input  wire [SAVE_ADDR_WIDTH:0]     raddr,
  output core_pkg::half_t             q
);

  core_pkg::half_t mem [2**SAVE_ADDR_WIDTH];

  // byte addresses, halfword index above bit 0
  always_ff @(posedge clk_74a) begin
    if (we) mem[waddr[SAVE_ADDR_WIDTH:1]] <= wdata;
    q <= mem[raddr[SAVE_ADDR_WIDTH:1]];
  end

endmodule

`default_nettype wire

//--- verilog/save_unloader.sv
////////////////////////////////////////////////////////////
// save unloader
// reads two halfwords from the save buffer per bridge read
// and holds the assembled word for the read mux
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module save_unloader #(
  parameter int SAVE_ADDR_WIDTH = 10
) (
  input  wire                         clk_74a,
  input  wire                         pll_core_locked,
  input  wire                         save_rd,
  input  wire core_pkg::bridge_addr_t rd_addr,
  input  wire core_pkg::half_t        buf_q,
  output logic [SAVE_ADDR_WIDTH:0]    buf_raddr,
  output core_pkg::bridge_data_t      save_rd_data
);

  localparam int PHASE_WIDTH = $clog2(core_pkg::READ_LATENCY);

  // phase counts down from READ_LATENCY-1 after the strobe
  localparam logic [PHASE_WIDTH-1:0] PH_LOWER_ADDR = PHASE_WIDTH'(core_pkg::READ_LATENCY - 1);
  localparam logic [PHASE_WIDTH-1:0] PH_UPPER_DATA = PHASE_WIDTH'(core_pkg::READ_LATENCY - 2);
  localparam logic [PHASE_WIDTH-1:0] PH_LOWER_DATA = PHASE_WIDTH'(1);

  logic [PHASE_WIDTH-1:0] phase;
  core_pkg::half_t        upper_half;

  always_ff @(posedge clk_74a) begin
    if (phase == PH_UPPER_DATA) upper_half <= buf_q;
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      phase        <= '0;
      buf_raddr    <= '0;
      save_rd_data <= '0;
    end else if (save_rd) begin
      phase     <= PH_LOWER_ADDR;
      buf_raddr <= {rd_addr[SAVE_ADDR_WIDTH:2], 2'b00};
    end else begin
      if (phase != '0) phase <= phase - PHASE_WIDTH'(1);
      // lower halfword sits at word address plus 2
      if (phase == PH_LOWER_ADDR) buf_raddr[1] <= 1'b1;
      if (phase == PH_LOWER_DATA) save_rd_data <= {upper_half, buf_q};
    end
  end

endmodule

`default_nettype wire
